// ==== hw/arch_map.sv ====
`timescale 1ns/10ps

module arch_map #(
  parameter int NUM_PHYS = rename_pkg::DEFAULT_NUM_PHYS,
  localparam int TAG_W = $clog2(NUM_PHYS)
) (
  input  logic                                          clock,
  input  logic                                          reset,
  input  logic                                          arch_write,
  input  isa_pkg::arch_reg_t                            retire_arch,
  input  logic [TAG_W-1:0]                              retire_tag,
  output logic [isa_pkg::NUM_ARCH_REGS-1:0][TAG_W-1:0]  next_map
);
  import isa_pkg::*;

  logic [NUM_ARCH_REGS-1:0][TAG_W-1:0] committed;

  // Next state goes out so a same-cycle rollback sees this retire.
  always_comb begin
    next_map = committed;
    if (arch_write) begin
      next_map[retire_arch] = retire_tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        committed[i] <= TAG_W'(i);
      end
    end else begin
      committed <= next_map;
    end
  end

  a_no_zero_write: assert property (@(posedge clock) disable iff (reset)
    arch_write |-> (retire_arch != ZERO_REG));

endmodule

// ==== hw/free_list.sv ====
`timescale 1ns/10ps

module free_list #(
  parameter int NUM_PHYS = rename_pkg::DEFAULT_NUM_PHYS,
  localparam int TAG_W    = $clog2(NUM_PHYS),
  localparam int FL_DEPTH = NUM_PHYS - isa_pkg::NUM_ARCH_REGS,
  localparam int PTR_W    = $clog2(FL_DEPTH)
) (
  input  logic     clock,
  input  logic     reset,
  free_list_if.list fl
);
  import isa_pkg::*;

  localparam int CNT_W = PTR_W + 1;

  logic [TAG_W-1:0] tags [FL_DEPTH];
  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] tail;
  logic [PTR_W-1:0] next_head;
  logic [PTR_W-1:0] next_tail;
  logic [PTR_W-1:0] free_dist;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] next_count;
  logic             take;
  logic             full;

  if (FL_DEPTH <= 0 || (FL_DEPTH & (FL_DEPTH - 1)) != 0) begin : g_depth_check
    $error("free_list depth %0d is not a power of two", FL_DEPTH);
  end

  // Rollback wins over a pop; a push still lands.
  assign take      = fl.pop && !fl.rollback;
  assign next_head = fl.push ? head + PTR_W'(1) : head;
  assign next_tail = fl.rollback ? fl.rollback_ptr : (take ? tail + PTR_W'(1) : tail);
  assign free_dist = next_head - fl.rollback_ptr;

  // After a squash every uncommitted tag is free, so a zero distance means full.
  always_comb begin
    if (fl.rollback) begin
      next_count = (free_dist == '0) ? CNT_W'(FL_DEPTH) : CNT_W'(free_dist);
    end else begin
      next_count = count + CNT_W'(fl.push) - CNT_W'(take);
    end
  end

  assign fl.head_tag = tags[tail];
  assign fl.empty    = (count == '0);
  assign fl.tail_ptr = next_tail;
  assign full        = (count == CNT_W'(FL_DEPTH));

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= CNT_W'(FL_DEPTH);
      for (int i = 0; i < FL_DEPTH; i++) begin
        tags[i] <= TAG_W'(NUM_ARCH_REGS + i);
      end
    end else begin
      head  <= next_head;
      tail  <= next_tail;
      count <= next_count;
      if (fl.push) begin
        tags[head] <= fl.push_tag;
      end
    end
  end

  a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
    fl.pop |-> !fl.empty);
  a_no_push_full: assert property (@(posedge clock) disable iff (reset)
    fl.push |-> !full);

endmodule

// ==== hw/free_list_if.sv ====
`timescale 1ns/10ps

interface free_list_if #(
  parameter int NUM_PHYS = rename_pkg::DEFAULT_NUM_PHYS
) ();
  import isa_pkg::*;

  localparam int TAG_W = $clog2(NUM_PHYS);
  localparam int PTR_W = $clog2(NUM_PHYS - NUM_ARCH_REGS);

  // Requests from the controller.
  logic             pop;
  logic             push;
  logic [TAG_W-1:0] push_tag;
  logic             rollback;
  logic [PTR_W-1:0] rollback_ptr;

  // Status from the free list.
  logic [TAG_W-1:0] head_tag;
  logic             empty;
  logic [PTR_W-1:0] tail_ptr;

  modport ctrl (output pop, push, push_tag, rollback, rollback_ptr,
                input  head_tag, empty, tail_ptr);
  modport list (input  pop, push, push_tag, rollback, rollback_ptr,
                output head_tag, empty, tail_ptr);

endinterface

// ==== hw/isa_pkg.sv ====
package isa_pkg;

  // ======================================================================
  // Architectural register file
  // ======================================================================

  // Integer registers visible to software.
  localparam int NUM_ARCH_REGS = 32;
  localparam int ARCH_REG_W    = $clog2(NUM_ARCH_REGS);

  typedef logic [ARCH_REG_W-1:0] arch_reg_t;

  // Hardwired zero register; reads as zero and ignores writes.
  localparam arch_reg_t ZERO_REG = '0;

endpackage

// ==== hw/map_if.sv ====
`timescale 1ns/10ps

interface map_if #(
  parameter int NUM_PHYS = rename_pkg::DEFAULT_NUM_PHYS
) ();
  import isa_pkg::*;

  localparam int TAG_W = $clog2(NUM_PHYS);

  // Lookup and update requests.
  arch_reg_t        src1_arch;
  arch_reg_t        src2_arch;
  arch_reg_t        dest_arch;
  logic             write;
  logic [TAG_W-1:0] write_tag;
  logic             restore;

  // Lookup results, combinational from the arch indices.
  logic [TAG_W-1:0] src1_tag;
  logic [TAG_W-1:0] src2_tag;
  logic [TAG_W-1:0] told_tag;

  modport ctrl (output src1_arch, src2_arch, dest_arch, write, write_tag, restore,
                input  src1_tag, src2_tag, told_tag);
  modport tbl  (input  src1_arch, src2_arch, dest_arch, write, write_tag, restore,
                output src1_tag, src2_tag, told_tag);

endinterface

// ==== hw/map_table.sv ====
`timescale 1ns/10ps

module map_table #(
  parameter int NUM_PHYS = rename_pkg::DEFAULT_NUM_PHYS,
  localparam int TAG_W = $clog2(NUM_PHYS)
) (
  input  logic                                            clock,
  input  logic                                            reset,
  map_if.tbl                                              map,
  input  logic [isa_pkg::NUM_ARCH_REGS-1:0][TAG_W-1:0]    committed_map
);
  import isa_pkg::*;
  import rename_pkg::*;

  logic [NUM_ARCH_REGS-1:0][TAG_W-1:0] entries;

  // Three read ports, all combinational.
  assign map.src1_tag = entries[map.src1_arch];
  assign map.src2_tag = entries[map.src2_arch];
  assign map.told_tag = entries[map.dest_arch];

  // Entry 0 is set once at reset and never touched again.
  always_ff @(posedge clock) begin
    if (reset) begin
      entries[0] <= TAG_W'(ZERO_TAG);
      for (int i = 1; i < NUM_ARCH_REGS; i++) begin
        entries[i] <= TAG_W'(i);
      end
    end else if (map.restore) begin
      for (int i = 1; i < NUM_ARCH_REGS; i++) begin
        entries[i] <= committed_map[i];
      end
    end else if (map.write && (map.dest_arch != ZERO_REG)) begin
      entries[map.dest_arch] <= map.write_tag;
    end
  end

endmodule

// ==== hw/rename_ctrl.sv ====
`timescale 1ns/10ps

module rename_ctrl #(
  parameter int NUM_PHYS = rename_pkg::DEFAULT_NUM_PHYS,
  localparam int TAG_W = $clog2(NUM_PHYS),
  localparam int PTR_W = $clog2(NUM_PHYS - isa_pkg::NUM_ARCH_REGS)
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               dispatch_en,
  input  isa_pkg::arch_reg_t src1_arch,
  input  isa_pkg::arch_reg_t src2_arch,
  input  isa_pkg::arch_reg_t dest_arch,
  input  logic               retire_en,
  input  isa_pkg::arch_reg_t retire_arch,
  input  logic [TAG_W-1:0]   retire_tag,
  input  logic [TAG_W-1:0]   retire_told,
  input  logic               rollback_en,
  input  logic [PTR_W-1:0]   rollback_ptr,
  free_list_if.ctrl          fl,
  map_if.ctrl                map,
  output logic               arch_write,
  output logic [TAG_W-1:0]   dest_tag,
  output logic               stall
);
  import isa_pkg::*;
  import rename_pkg::*;

  localparam logic [TAG_W-1:0] ZTAG = TAG_W'(ZERO_TAG);

  logic needs_tag;
  logic alloc;

  // ======================================================================
  // Dispatch
  // ======================================================================

  // Only a nonzero destination consumes a free tag.
  assign needs_tag = dispatch_en && (dest_arch != ZERO_REG);
  assign stall     = needs_tag && fl.empty;
  assign alloc     = needs_tag && !fl.empty;

  assign dest_tag = (dest_arch == ZERO_REG) ? ZTAG : fl.head_tag;

  assign map.src1_arch = src1_arch;
  assign map.src2_arch = src2_arch;
  assign map.dest_arch = dest_arch;
  assign map.write     = alloc;
  assign map.write_tag = fl.head_tag;
  assign map.restore   = rollback_en;

  assign fl.pop = alloc;

  // ======================================================================
  // Retire and rollback
  // ======================================================================

  assign fl.push      = retire_en && (retire_told != ZTAG);
  assign fl.push_tag  = retire_told;
  assign arch_write   = retire_en && (retire_arch != ZERO_REG);

  assign fl.rollback     = rollback_en;
  assign fl.rollback_ptr = rollback_ptr;

  // The ROB squashes before it dispatches again.
  a_no_dispatch_rollback: assert property (@(posedge clock) disable iff (reset)
    !(dispatch_en && rollback_en));

  // A retiring instruction frees the mapping it replaced, never its own.
  a_told_not_new: assert property (@(posedge clock) disable iff (reset)
    arch_write |-> (retire_told != retire_tag));

endmodule

// ==== hw/rename_pkg.sv ====
package rename_pkg;

  // ======================================================================
  // Rename microarchitecture
  // ======================================================================

  // Size of the unified physical register file.
  // Must leave a power-of-two free list above the architectural set.
  localparam int DEFAULT_NUM_PHYS = 64;

  // Physical tag that permanently backs the zero register.
  // It is never handed out by the free list and never returned to it.
  localparam int unsigned ZERO_TAG = 0;

endpackage

// ==== hw/rename_unit.sv ====
`timescale 1ns/10ps

module rename_unit #(
  parameter int NUM_PHYS = rename_pkg::DEFAULT_NUM_PHYS,
  localparam int TAG_W = $clog2(NUM_PHYS),
  localparam int PTR_W = $clog2(NUM_PHYS - isa_pkg::NUM_ARCH_REGS)
) (
  input  logic               clock,
  input  logic               reset,
  input  logic               dispatch_en,
  input  isa_pkg::arch_reg_t src1_arch,
  input  isa_pkg::arch_reg_t src2_arch,
  input  isa_pkg::arch_reg_t dest_arch,
  input  logic               retire_en,
  input  isa_pkg::arch_reg_t retire_arch,
  input  logic [TAG_W-1:0]   retire_tag,
  input  logic [TAG_W-1:0]   retire_told,
  input  logic               rollback_en,
  input  logic [PTR_W-1:0]   rollback_ptr,
  output logic [TAG_W-1:0]   src1_tag,
  output logic [TAG_W-1:0]   src2_tag,
  output logic [TAG_W-1:0]   dest_tag,
  output logic [TAG_W-1:0]   told_tag,
  output logic [PTR_W-1:0]   free_ptr,
  output logic               stall
);
  import isa_pkg::*;

  logic                                arch_write;
  logic [NUM_ARCH_REGS-1:0][TAG_W-1:0] committed_map;

  free_list_if #(.NUM_PHYS(NUM_PHYS)) fl_bus ();
  map_if       #(.NUM_PHYS(NUM_PHYS)) map_bus ();

  rename_ctrl #(.NUM_PHYS(NUM_PHYS)) i_rename_ctrl (
    .clock, .reset,
    .dispatch_en, .src1_arch, .src2_arch, .dest_arch,
    .retire_en, .retire_arch, .retire_tag, .retire_told,
    .rollback_en, .rollback_ptr,
    .fl(fl_bus.ctrl), .map(map_bus.ctrl),
    .arch_write, .dest_tag, .stall
  );

  free_list #(.NUM_PHYS(NUM_PHYS)) i_free_list (
    .clock, .reset, .fl(fl_bus.list)
  );

  map_table #(.NUM_PHYS(NUM_PHYS)) i_map_table (
    .clock, .reset, .map(map_bus.tbl), .committed_map
  );

  arch_map #(.NUM_PHYS(NUM_PHYS)) i_arch_map (
    .clock, .reset, .arch_write, .retire_arch, .retire_tag,
    .next_map(committed_map)
  );

  assign src1_tag = map_bus.src1_tag;
  assign src2_tag = map_bus.src2_tag;
  assign told_tag = map_bus.told_tag;
  assign free_ptr = fl_bus.tail_ptr;

endmodule

// ==== rename_unit.f ====
hw/isa_pkg.sv
hw/rename_pkg.sv
hw/free_list_if.sv
hw/map_if.sv
hw/rename_ctrl.sv
hw/free_list.sv
hw/map_table.sv
hw/arch_map.sv
hw/rename_unit.sv
tb/rename_checker.sv
tb/tb_rename_unit.sv

// ==== tb/rename_checker.sv ====
`timescale 1ns/10ps

module rename_checker (
  input  logic       clock,
  input  logic       valid,
  input  int         line_no,
  input  logic [5:0] mask,
  input  int         exp_src1,
  input  int         exp_src2,
  input  int         exp_dest,
  input  int         exp_told,
  input  int         exp_fptr,
  input  int         exp_stall,
  input  int         act_src1,
  input  int         act_src2,
  input  int         act_dest,
  input  int         act_told,
  input  int         act_fptr,
  input  int         act_stall,
  output int         error_count,
  output int         check_count
);

  initial begin
    error_count = 0;
    check_count = 0;
  end

  task automatic compare_field(input string name, input bit enabled, input int expected,
                               input int actual);
    if (enabled) begin
      check_count++;
      if (expected != actual) begin
        error_count++;
        $display("CHECK FAILED trace line %0d %s: expected %0d, actual %0d",
                 line_no, name, expected, actual);
      end
    end
  endtask

  // Inputs change 1 ns after the rising edge, so the falling edge sees them settled.
  always @(negedge clock) begin
    if (valid) begin
      compare_field("src1_tag", mask[0], exp_src1, act_src1);
      compare_field("src2_tag", mask[1], exp_src2, act_src2);
      compare_field("dest_tag", mask[2], exp_dest, act_dest);
      compare_field("told_tag", mask[3], exp_told, act_told);
      compare_field("free_ptr", mask[4], exp_fptr, act_fptr);
      compare_field("stall", mask[5], exp_stall, act_stall);
    end
  end

endmodule

// ==== tb/rename_trace.txt ====
# dispatch src1 src2 dest | retire arch tag told | rollback ptr | check mask (bit0 src1 .. bit5 stall)
# expected: src1_tag src2_tag dest_tag told_tag free_ptr stall
1 1 2 3 0 0 0 0 0 0 63 1 2 32 3 1 0
1 3 0 3 0 0 0 0 0 0 63 32 0 33 32 2 0
1 3 4 0 0 0 0 0 0 0 63 33 4 0 0 2 0
1 5 3 5 0 0 0 0 0 0 63 5 33 34 5 3 0
0 3 5 0 1 3 32 3 1 1 63 33 34 0 0 1 0
1 3 5 6 0 0 0 0 0 0 63 32 5 33 6 2 0
1 0 0 7 0 0 0 0 0 0 52 0 0 34 0 3 0
1 0 0 7 0 0 0 0 0 0 52 0 0 35 0 4 0
1 0 0 7 0 0 0 0 0 0 52 0 0 36 0 5 0
1 0 0 7 0 0 0 0 0 0 52 0 0 37 0 6 0
1 0 0 7 0 0 0 0 0 0 52 0 0 38 0 7 0
1 0 0 7 0 0 0 0 0 0 52 0 0 39 0 8 0
1 0 0 7 0 0 0 0 0 0 52 0 0 40 0 9 0
1 0 0 7 0 0 0 0 0 0 52 0 0 41 0 10 0
1 0 0 7 0 0 0 0 0 0 52 0 0 42 0 11 0
1 0 0 7 0 0 0 0 0 0 52 0 0 43 0 12 0
1 0 0 7 0 0 0 0 0 0 52 0 0 44 0 13 0
1 0 0 7 0 0 0 0 0 0 52 0 0 45 0 14 0
1 0 0 7 0 0 0 0 0 0 52 0 0 46 0 15 0
1 0 0 7 0 0 0 0 0 0 52 0 0 47 0 16 0
1 0 0 7 0 0 0 0 0 0 52 0 0 48 0 17 0
1 0 0 7 0 0 0 0 0 0 52 0 0 49 0 18 0
1 0 0 7 0 0 0 0 0 0 52 0 0 50 0 19 0
1 0 0 7 0 0 0 0 0 0 52 0 0 51 0 20 0
1 0 0 7 0 0 0 0 0 0 52 0 0 52 0 21 0
1 0 0 7 0 0 0 0 0 0 52 0 0 53 0 22 0
1 0 0 7 0 0 0 0 0 0 52 0 0 54 0 23 0
1 0 0 7 0 0 0 0 0 0 52 0 0 55 0 24 0
1 0 0 7 0 0 0 0 0 0 52 0 0 56 0 25 0
1 0 0 7 0 0 0 0 0 0 52 0 0 57 0 26 0
1 0 0 7 0 0 0 0 0 0 52 0 0 58 0 27 0
1 0 0 7 0 0 0 0 0 0 52 0 0 59 0 28 0
1 0 0 7 0 0 0 0 0 0 52 0 0 60 0 29 0
1 0 0 7 0 0 0 0 0 0 52 0 0 61 0 30 0
1 0 0 7 0 0 0 0 0 0 52 0 0 62 0 31 0
1 0 0 7 0 0 0 0 0 0 52 0 0 63 0 0 0
1 0 0 7 0 0 0 0 0 0 52 0 0 3 0 1 0
1 0 0 8 0 0 0 0 0 0 56 0 0 0 8 1 1
1 0 0 8 1 6 33 6 0 0 56 0 0 0 8 1 1
1 6 0 8 0 0 0 0 0 0 63 33 0 6 8 2 0

// ==== tb/tb_rename_unit.sv ====
`timescale 1ns/10ps

module tb_rename_unit;
  localparam int NUM_PHYS = 64;
  localparam int TAG_W = $clog2(NUM_PHYS);
  localparam int PTR_W = $clog2(NUM_PHYS - 32);
  localparam int MAX_LINES = 64;
  localparam int NUM_COLS = 17;

  logic clock, reset, dispatch_en, retire_en, rollback_en, check_valid;
  logic [4:0] src1_arch, src2_arch, dest_arch, retire_arch;
  logic [TAG_W-1:0] retire_tag, retire_told, src1_tag, src2_tag, dest_tag, told_tag;
  logic [PTR_W-1:0] rollback_ptr, free_ptr;
  logic stall;
  logic [5:0] mask;
  int exp_val [6];
  int cols [MAX_LINES][NUM_COLS];
  int line_nos [MAX_LINES];
  int num_lines, cur_line, error_count, check_count;
  int trace_errors;
  bit trace_loaded;

  rename_unit #(.NUM_PHYS(NUM_PHYS)) i_rename_unit (.*);

  rename_checker i_checker (
    .clock, .valid(check_valid), .line_no(cur_line), .mask,
    .exp_src1(exp_val[0]), .exp_src2(exp_val[1]), .exp_dest(exp_val[2]),
    .exp_told(exp_val[3]), .exp_fptr(exp_val[4]), .exp_stall(exp_val[5]),
    .act_src1(int'(src1_tag)), .act_src2(int'(src2_tag)), .act_dest(int'(dest_tag)),
    .act_told(int'(told_tag)), .act_fptr(int'(free_ptr)), .act_stall(int'(stall)),
    .error_count, .check_count
  );

  always #4 clock = ~clock;

  task automatic load_trace();
    int fd, n, file_line;
    string text;
    fd = $fopen("tb/rename_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/rename_trace.txt");
    end else begin
      file_line = 0;
      while (!$feof(fd) && num_lines < MAX_LINES) begin
        text = "";
        n = $fgets(text, fd);
        file_line++;
        if (text.len() > 1 && text[0] != "#") begin
          n = $sscanf(text, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
            cols[num_lines][0], cols[num_lines][1], cols[num_lines][2],
            cols[num_lines][3], cols[num_lines][4], cols[num_lines][5],
            cols[num_lines][6], cols[num_lines][7], cols[num_lines][8],
            cols[num_lines][9], cols[num_lines][10], cols[num_lines][11],
            cols[num_lines][12], cols[num_lines][13], cols[num_lines][14],
            cols[num_lines][15], cols[num_lines][16]);
          if (n != NUM_COLS) begin
            $display("Trace line %0d has %0d fields instead of %0d",
                     file_line, n, NUM_COLS);
            trace_errors++;
          end
          line_nos[num_lines] = file_line;
          num_lines++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic apply_line(input int idx);
    {dispatch_en, src1_arch, src2_arch, dest_arch} =
      {1'(cols[idx][0]), 5'(cols[idx][1]), 5'(cols[idx][2]), 5'(cols[idx][3])};
    {retire_en, retire_arch} = {1'(cols[idx][4]), 5'(cols[idx][5])};
    retire_tag   = TAG_W'(cols[idx][6]);
    retire_told  = TAG_W'(cols[idx][7]);
    rollback_en  = 1'(cols[idx][8]);
    rollback_ptr = PTR_W'(cols[idx][9]);
    mask         = 6'(cols[idx][10]);
    for (int f = 0; f < 6; f++) begin
      exp_val[f] = cols[idx][11 + f];
    end
    cur_line    = line_nos[idx];
    check_valid = 1'b1;
  endtask

  // ======================================================================
  // Stimulus
  // ======================================================================
  initial begin
    {clock, dispatch_en, retire_en, rollback_en, check_valid} = '0;
    {src1_arch, src2_arch, dest_arch, retire_arch} = '0;
    {retire_tag, retire_told, rollback_ptr, mask} = '0;
    reset = 1'b1;
    cur_line = 0;
    num_lines = 0;
    trace_errors = 0;
    for (int f = 0; f < 6; f++) begin
      exp_val[f] = 0;
    end
    load_trace();
    if (num_lines == 0 || trace_errors != 0) begin
      $display("The trace could not be read, so no checks were run");
      $display("Regression failed");
      $finish;
    end else begin
      trace_loaded = 1'b1;
      repeat (4) @(posedge clock);
      #1 reset = 1'b0;
      for (int i = 0; i < num_lines; i++) begin
        apply_line(i);
        @(posedge clock);
        #1;
      end
      {check_valid, dispatch_en, retire_en, rollback_en} = '0;
      $display("Checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0 && check_count > 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

  // Watchdog.
  initial begin
    wait (trace_loaded);
    #((num_lines + 20) * 8);
    $display("Timeout: the trace did not finish in the expected time");
    $display("Regression failed");
    $finish;
  end

endmodule
